// ==== source/aes_consts.svh ====
`ifndef AES_CONSTS_SVH
`define AES_CONSTS_SVH

// width of one data block and of one round key
`define AES_BLOCK_W 128

// aes-256 key schedule depth and round count
`define AES_NUM_ROUND_KEYS 15
`define AES_NUM_ROUNDS 14
`define AES_KEY_ADDR_W 4

// command queue entries
`define AES_FIFO_DEPTH 8

`endif

// ==== source/aes_pkg.sv ====
`include "aes_consts.svh"

package aes_pkg;

    // one data block or one round key
    typedef logic [`AES_BLOCK_W-1:0] block_t;

    // opcode sent along with every host strobe
    typedef enum logic [1:0]
    {
        mode_encrypt  = 2'd0,
        mode_key_high = 2'd1,
        mode_key_low  = 2'd2
    } mode_t;

    // one queue entry
    typedef struct packed
    {
        mode_t  mode;
        block_t data;
    } command_t;

    // write port of the round-key store
    typedef struct packed
    {
        logic                       enable;
        logic [`AES_KEY_ADDR_W-1:0] addr;
        block_t                     round_key;
    } key_write_t;

    // multiply by x, reduced by x^8 + x^4 + x^3 + x + 1
    function automatic logic [7:0] xtime(input logic [7:0] a);
        return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] acc;
        logic [7:0] sh;
        acc = 8'h00;
        sh = a;
        for (int i = 0; i < 8; i++)
        begin
            if (b[i])
                acc ^= sh;
            sh = xtime(sh);
        end
        return acc;
    endfunction

    // forward s-box, field inverse then affine map
    function automatic logic [7:0] sbox(input logic [7:0] x);
        logic [7:0] p;
        logic [7:0] inv;
        p = x;
        inv = 8'h01;
        // x^254 = x^2 * x^4 * ... * x^128, zero stays zero
        for (int i = 1; i < 8; i++)
        begin
            p = gf_mul(p, p);
            inv = gf_mul(inv, p);
        end
        return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]}
            ^ {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;
    endfunction

    function automatic logic [31:0] sub_word(input logic [31:0] w);
        return {sbox(w[31:24]), sbox(w[23:16]), sbox(w[15:8]), sbox(w[7:0])};
    endfunction

    // sub bytes, shift rows, mix columns; last round skips mix columns
    function automatic block_t round_transform(input block_t s, input logic last);
        logic [7:0] sb [16];
        logic [7:0] sr [16];
        logic [7:0] a [4];
        logic [7:0] all;
        block_t r;
        // byte i sits at row i%4, column i/4
        for (int i = 0; i < 16; i++)
            sb[i] = sbox(s[`AES_BLOCK_W-1-8*i -: 8]);
        // row n rotates left by n columns
        for (int c = 0; c < 4; c++)
            for (int row = 0; row < 4; row++)
                sr[row+4*c] = sb[row+4*((c+row)%4)];
        for (int c = 0; c < 4; c++)
        begin
            for (int row = 0; row < 4; row++)
                a[row] = sr[row+4*c];
            all = a[0] ^ a[1] ^ a[2] ^ a[3];
            // 2a ^ 3b ^ c ^ d written as a ^ all ^ 2(a ^ b)
            for (int row = 0; row < 4; row++)
                r[`AES_BLOCK_W-1-8*(row+4*c) -: 8] = last ? a[row]
                    : a[row] ^ all ^ xtime(a[row] ^ a[(row+1)%4]);
        end
        return r;
    endfunction

endpackage

// ==== source/aes_command_fifo.sv ====
`timescale 1ns/1ps
`include "aes_consts.svh"

module aes_command_fifo
(
    input  logic              clk,
    input  logic              resetn,
    input  logic              in_valid,
    input  aes_pkg::command_t in_command,
    input  logic              pop,
    output aes_pkg::command_t head,
    output logic              not_empty
);
    import aes_pkg::*;

    localparam int PTR_W = $clog2(`AES_FIFO_DEPTH);

    command_t         mem [`AES_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             push;

    // no back-pressure, a strobe at full count is lost
    assign push = in_valid && (count != `AES_FIFO_DEPTH);

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            // pointers wrap on their own, depth is a power of two
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= in_command;
    end

    // head entry shown straight from the array
    assign head = mem[rd_ptr];
    assign not_empty = (count != '0);

    // dispatch must only pop a present entry
    pop_needs_entry: assert property (@(posedge clk) disable iff (!resetn)
        pop |-> not_empty);

endmodule

// ==== source/aes_dispatch.sv ====
`timescale 1ns/1ps

module aes_dispatch
(
    input  logic                  clk,
    input  logic                  resetn,
    input  aes_pkg::command_t     head,
    input  logic                  not_empty,
    output logic                  pop,
    output logic                  expand_start,
    output aes_pkg::block_t [1:0] cipher_key,
    input  logic                  expand_done,
    output logic                  cipher_start,
    output aes_pkg::block_t       plaintext,
    input  logic                  cipher_busy
);
    import aes_pkg::*;

    typedef enum logic
    {
        st_idle,
        st_key_wait
    } dispatch_state_t;

    dispatch_state_t state;
    block_t          key_high;
    logic            key_ready;

    // head is only examined while idle
    // nothing leaves the queue while a block is in the cipher
    always_comb
    begin
        pop = 1'b0;
        expand_start = 1'b0;
        cipher_start = 1'b0;
        if (state == st_idle && not_empty && !cipher_busy)
        begin
            case (head.mode)
                mode_key_high:
                    pop = 1'b1;
                mode_key_low:
                begin
                    pop = 1'b1;
                    expand_start = 1'b1;
                end
                mode_encrypt:
                begin
                    // held at the head until a full key is stored
                    pop = key_ready;
                    cipher_start = key_ready;
                end
                default:
                    // unknown opcode, drop it
                    pop = 1'b1;
            endcase
        end
    end

    // index 1 is the high half, round keys 0..1 are high then low
    assign cipher_key = {key_high, head.data};
    assign plaintext = head.data;

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            state <= st_idle;
            key_ready <= 1'b0;
        end
        else
        begin
            case (state)
                st_idle:
                    if (expand_start)
                        state <= st_key_wait;
                st_key_wait:
                    if (expand_done)
                        state <= st_idle;
                default:
                    state <= st_idle;
            endcase
            if (expand_done)
                key_ready <= 1'b1;
            else if (expand_start || (pop && head.mode == mode_key_high))
                key_ready <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (pop && head.mode == mode_key_high)
            key_high <= head.data;
    end

    // cipher takes the block on the edge after its start
    start_taken: assert property (@(posedge clk) disable iff (!resetn)
        cipher_start |=> cipher_busy);

    // expansion only ends one that was started from here
    done_in_key_wait: assert property (@(posedge clk) disable iff (!resetn)
        expand_done |-> state == st_key_wait);

endmodule

// ==== source/aes_key_expand.sv ====
`timescale 1ns/1ps
`include "aes_consts.svh"

module aes_key_expand
(
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  expand_start,
    input  aes_pkg::block_t [1:0] cipher_key,
    output aes_pkg::key_write_t   key_write,
    output logic                  expand_done
);
    import aes_pkg::*;

    localparam int LAST_KEY = `AES_NUM_ROUND_KEYS - 1;

    // older is the key written this cycle, newer the one after it
    block_t                     older;
    block_t                     newer;
    block_t                     next_key;
    logic [`AES_KEY_ADDR_W-1:0] idx;
    logic                       busy;
    logic [7:0]                 rcon;
    logic [31:0]                temp;
    logic [31:0]                w [4];

    // next key has index idx + 2, same parity as idx
    always_comb
    begin
        if (!idx[0])
            // even: rotate, substitute, add round constant
            temp = sub_word({newer[23:0], newer[31:24]}) ^ {rcon, 24'h000000};
        else
            // odd: substitute only
            temp = sub_word(newer[31:0]);
        w[0] = older[127:96] ^ temp;
        w[1] = older[95:64] ^ w[0];
        w[2] = older[63:32] ^ w[1];
        w[3] = older[31:0] ^ w[2];
        next_key = {w[0], w[1], w[2], w[3]};
    end

    assign key_write = '{enable: busy, addr: idx, round_key: older};
    // last write and done share the cycle
    assign expand_done = busy && (idx == LAST_KEY);

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            busy <= 1'b0;
            idx <= '0;
            rcon <= 8'h01;
        end
        else if (expand_start)
        begin
            busy <= 1'b1;
            idx <= '0;
            rcon <= 8'h01;
        end
        else if (busy)
        begin
            idx <= idx + 1'b1;
            // constant doubles after each even step
            if (!idx[0])
                rcon <= xtime(rcon);
            if (idx == LAST_KEY)
                busy <= 1'b0;
        end
    end

    // two-key sliding window
    always_ff @(posedge clk)
    begin
        if (expand_start)
        begin
            older <= cipher_key[1];
            newer <= cipher_key[0];
        end
        else if (busy)
        begin
            older <= newer;
            newer <= next_key;
        end
    end

endmodule

// ==== source/aes_round_key_store.sv ====
`timescale 1ns/1ps
`include "aes_consts.svh"

module aes_round_key_store
(
    input  logic                       clk,
    input  aes_pkg::key_write_t        key_write,
    input  logic [`AES_KEY_ADDR_W-1:0] key_addr,
    output aes_pkg::block_t            round_key
);
    import aes_pkg::*;

    block_t mem [`AES_NUM_ROUND_KEYS];

    always_ff @(posedge clk)
    begin
        if (key_write.enable)
            mem[key_write.addr] <= key_write.round_key;
    end

    // read data one cycle after the address
    always_ff @(posedge clk)
    begin
        round_key <= mem[key_addr];
    end

    // schedule writes only keys 0..14
    write_in_range: assert property (@(posedge clk)
        key_write.enable |-> key_write.addr < `AES_NUM_ROUND_KEYS);

endmodule

// ==== source/aes_cipher_rounds.sv ====
`timescale 1ns/1ps
`include "aes_consts.svh"

module aes_cipher_rounds
(
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       cipher_start,
    input  aes_pkg::block_t            plaintext,
    output logic [`AES_KEY_ADDR_W-1:0] key_addr,
    input  aes_pkg::block_t            round_key,
    output logic                       cipher_busy,
    output logic                       out_valid,
    output aes_pkg::block_t            out_data
);
    import aes_pkg::*;

    localparam int LAST_ROUND = `AES_NUM_ROUNDS;

    block_t                     state;
    block_t                     round_in;
    block_t                     round_out;
    // index of the round key arriving this cycle
    logic [`AES_KEY_ADDR_W-1:0] rnd;

    // round 0 is the bare key addition
    always_comb
    begin
        if (rnd == '0)
            round_in = state;
        else
            round_in = round_transform(state, rnd == LAST_ROUND);
        round_out = round_in ^ round_key;
    end

    // key_addr rests at 0 when idle, so key 0 is read on the start cycle
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            cipher_busy <= 1'b0;
            rnd <= '0;
            key_addr <= '0;
            out_valid <= 1'b0;
        end
        else
        begin
            out_valid <= 1'b0;
            if (cipher_start)
            begin
                cipher_busy <= 1'b1;
                rnd <= '0;
                key_addr <= 1;
            end
            else if (cipher_busy)
            begin
                rnd <= rnd + 1'b1;
                // address runs one ahead, back to 0 after key 14
                if (rnd < LAST_ROUND - 1)
                    key_addr <= key_addr + 1'b1;
                else
                    key_addr <= '0;
                if (rnd == LAST_ROUND)
                begin
                    cipher_busy <= 1'b0;
                    out_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (cipher_start)
            state <= plaintext;
        else if (cipher_busy)
            state <= round_out;
        // result held until the next block finishes
        if (cipher_busy && rnd == LAST_ROUND)
            out_data <= round_out;
    end

    // fixed latency through the key store and all rounds
    fixed_latency: assert property (@(posedge clk) disable iff (!resetn)
        cipher_start |-> ##16 out_valid);

endmodule

// ==== source/aes256_device.sv ====
`timescale 1ns/1ps
`include "aes_consts.svh"

module aes256_device
(
    input  logic            clk,
    input  logic            resetn,
    input  logic            in_valid,
    input  aes_pkg::mode_t  in_mode,
    input  aes_pkg::block_t in_data,
    output logic            out_valid,
    output aes_pkg::block_t out_data
);
    import aes_pkg::*;

    command_t                   in_command;
    command_t                   head;
    logic                       not_empty;
    logic                       pop;
    logic                       expand_start;
    logic                       expand_done;
    block_t [1:0]               cipher_key;
    key_write_t                 key_write;
    logic                       cipher_start;
    logic                       cipher_busy;
    block_t                     plaintext;
    logic [`AES_KEY_ADDR_W-1:0] key_addr;
    block_t                     round_key;

    // opcode and data queue together
    assign in_command = '{mode: in_mode, data: in_data};

    aes_command_fifo aes_command_fifo_inst
    (
        .clk        (clk),
        .resetn     (resetn),
        .in_valid   (in_valid),
        .in_command (in_command),
        .pop        (pop),
        .head       (head),
        .not_empty  (not_empty)
    );

    aes_dispatch aes_dispatch_inst
    (
        .clk          (clk),
        .resetn       (resetn),
        .head         (head),
        .not_empty    (not_empty),
        .pop          (pop),
        .expand_start (expand_start),
        .cipher_key   (cipher_key),
        .expand_done  (expand_done),
        .cipher_start (cipher_start),
        .plaintext    (plaintext),
        .cipher_busy  (cipher_busy)
    );

    aes_key_expand aes_key_expand_inst
    (
        .clk          (clk),
        .resetn       (resetn),
        .expand_start (expand_start),
        .cipher_key   (cipher_key),
        .key_write    (key_write),
        .expand_done  (expand_done)
    );

    aes_round_key_store aes_round_key_store_inst
    (
        .clk       (clk),
        .key_write (key_write),
        .key_addr  (key_addr),
        .round_key (round_key)
    );

    aes_cipher_rounds aes_cipher_rounds_inst
    (
        .clk          (clk),
        .resetn       (resetn),
        .cipher_start (cipher_start),
        .plaintext    (plaintext),
        .key_addr     (key_addr),
        .round_key    (round_key),
        .cipher_busy  (cipher_busy),
        .out_valid    (out_valid),
        .out_data     (out_data)
    );

endmodule

// ==== tests/aes_model.svh ====
`ifndef AES_MODEL_SVH
`define AES_MODEL_SVH

// reference s-box, filled once before the first encryption
logic [7:0] sbox_table [256];

// schoolbook product then reduction by 0x11b
function automatic logic [7:0] field_mul(input logic [7:0] a, input logic [7:0] b);
    logic [15:0] p;
    p = '0;
    for (int i = 0; i < 8; i++)
        if (b[i])
            p ^= 16'(a) << i;
    for (int i = 15; i >= 8; i--)
        if (p[i])
            p ^= 16'h011b << (i - 8);
    return p[7:0];
endfunction

function automatic void build_sbox_table();
    logic [7:0] inv;
    logic [7:0] b;
    for (int x = 0; x < 256; x++)
    begin
        // inverse found by search, zero keeps zero
        inv = 8'h00;
        for (int y = 1; y < 256; y++)
            if (field_mul(8'(x), 8'(y)) == 8'h01)
                inv = 8'(y);
        // affine map, bit form as in the standard
        for (int i = 0; i < 8; i++)
            b[i] = inv[i] ^ inv[(i + 4) % 8] ^ inv[(i + 5) % 8]
                ^ inv[(i + 6) % 8] ^ inv[(i + 7) % 8];
        sbox_table[x] = b ^ 8'h63;
    end
endfunction

function automatic logic [31:0] model_sub_word(input logic [31:0] t);
    return {sbox_table[t[31:24]], sbox_table[t[23:16]], sbox_table[t[15:8]],
        sbox_table[t[7:0]]};
endfunction

// aes-256 encryption of one block
function automatic logic [127:0] model_encrypt(input logic [255:0] key,
                                               input logic [127:0] pt);
    logic [31:0]  w [60];
    logic [31:0]  t;
    logic [7:0]   rc;
    logic [7:0]   s [16];
    logic [7:0]   u [16];
    logic [127:0] ct;
    rc = 8'h01;
    // eight key words, then the schedule
    for (int i = 0; i < 8; i++)
        w[i] = key[255 - 32 * i -: 32];
    for (int i = 8; i < 60; i++)
    begin
        t = w[i - 1];
        if (i % 8 == 0)
        begin
            t = model_sub_word({t[23:0], t[31:24]}) ^ {rc, 24'h000000};
            rc = field_mul(rc, 8'h02);
        end
        else if (i % 8 == 4)
            t = model_sub_word(t);
        w[i] = w[i - 8] ^ t;
    end
    // initial key addition
    for (int i = 0; i < 16; i++)
        s[i] = pt[127 - 8 * i -: 8] ^ w[i / 4][31 - 8 * (i % 4) -: 8];
    for (int r = 1; r <= 14; r++)
    begin
        // sub bytes with shift rows folded in
        for (int c = 0; c < 4; c++)
            for (int row = 0; row < 4; row++)
                u[row + 4 * c] = sbox_table[s[row + 4 * ((c + row) % 4)]];
        for (int c = 0; c < 4; c++)
            for (int row = 0; row < 4; row++)
                if (r < 14)
                    s[row + 4 * c] = field_mul(u[row + 4 * c], 8'h02)
                        ^ field_mul(u[(row + 1) % 4 + 4 * c], 8'h03)
                        ^ u[(row + 2) % 4 + 4 * c] ^ u[(row + 3) % 4 + 4 * c];
                else
                    s[row + 4 * c] = u[row + 4 * c];
        for (int i = 0; i < 16; i++)
            s[i] ^= w[4 * r + i / 4][31 - 8 * (i % 4) -: 8];
    end
    for (int i = 0; i < 16; i++)
        ct[127 - 8 * i -: 8] = s[i];
    return ct;
endfunction

`endif

// ==== tests/aes256_device_tb.sv ====
`timescale 1ns/1ps
`include "aes_consts.svh"

module aes256_device_tb;
    import aes_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int NUM_TESTS = 5;
    localparam int CYCLES_PER_TEST = 400;

    logic   clk;
    logic   resetn;
    logic   in_valid;
    mode_t  in_mode;
    block_t in_data;
    logic   out_valid;
    block_t out_data;

    logic [15:0] lfsr;
    block_t      expected [$];
    block_t      results [$];
    time         result_times [$];
    int          errors;
    int          test_errors;
    int          tests_failed;

    `include "aes_model.svh"

    aes256_device aes256_device_inst
    (
        .clk       (clk),
        .resetn    (resetn),
        .in_valid  (in_valid),
        .in_mode   (in_mode),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #(CLK_PERIOD / 2) clk = ~clk;
    end

    // dut outputs move on the rising edge, read them on the falling one
    always @(negedge clk)
    begin
        if (out_valid)
        begin
            results.push_back(out_data);
            result_times.push_back($time);
        end
    end

    // budget of 400 cycles per test
    initial
    begin
        #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
        $display("timeout: the run did not finish in the cycle budget");
        $display("Some tests failed");
        $finish;
    end

    // galois lfsr, taps 16 14 13 11, one step per bit
    function automatic block_t random_block();
        block_t v;
        for (int i = 0; i < 128; i++)
        begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
            v[i] = lfsr[0];
        end
        return v;
    endfunction

    // caller sits on a falling edge
    task automatic apply_reset();
        resetn = 1'b0;
        repeat (2)
            @(negedge clk);
        resetn = 1'b1;
    endtask

    // held for one cycle unless the next command follows
    task automatic drive_command(input mode_t mode, input block_t data);
        @(negedge clk);
        in_valid = 1'b1;
        in_mode = mode;
        in_data = data;
    endtask

    task automatic release_inputs();
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    // high half goes first
    task automatic load_key(input logic [255:0] key);
        drive_command(mode_key_high, key[255:128]);
        drive_command(mode_key_low, key[127:0]);
    endtask

    task automatic send_block(input logic [255:0] key, input block_t pt);
        expected.push_back(model_encrypt(key, pt));
        drive_command(mode_encrypt, pt);
    endtask

    task automatic report_error(input string msg);
        $display("FAILED at %0d ns: %s", $time, msg);
        errors++;
    endtask

    task automatic wait_for_results(input int count);
        int waited;
        waited = 0;
        while (results.size() < count && waited < CYCLES_PER_TEST)
        begin
            @(negedge clk);
            waited++;
        end
        if (results.size() < count)
        begin
            $display("error: only %0d of %0d results came out within %0d cycles",
                results.size(), count, CYCLES_PER_TEST);
            errors++;
        end
    endtask

    // compare collected results with the model, then clear for the next test
    task automatic close_test(input string name);
        wait_for_results(expected.size());
        // surplus results would land in this window
        repeat (20)
            @(negedge clk);
        if (results.size() != expected.size())
            report_error($sformatf("%s: %0d results, expected %0d", name,
                results.size(), expected.size()));
        for (int i = 0; i < expected.size() && i < results.size(); i++)
            if (results[i] !== expected[i])
                report_error($sformatf("%s: result %0d is %h, expected %h", name, i,
                    results[i], expected[i]));
        if (errors != test_errors)
            tests_failed++;
        $display("%s: %s", name, (errors == test_errors) ? "ok" : "errors found");
        test_errors = errors;
        expected.delete();
        results.delete();
        result_times.delete();
    endtask

    initial
    begin
        logic [255:0] key_a;
        logic [255:0] key_b;
        time          sent_time;
        block_t       pt;
        resetn = 1'b0;
        in_valid = 1'b0;
        in_mode = mode_encrypt;
        in_data = '0;
        lfsr = 16'd33201;
        errors = 0;
        test_errors = 0;
        tests_failed = 0;
        build_sbox_table();
        apply_reset();

        // fips-197 appendix c.3
        key_a = 256'h000102030405060708090a0b0c0d0e0f101112131415161718191a1b1c1d1e1f;
        pt = 128'h00112233445566778899aabbccddeeff;
        if (model_encrypt(key_a, pt) !== 128'h8ea2b7ca516745bfeafc49904b496089)
            report_error("reference model disagrees with the known answer");
        load_key(key_a);
        expected.push_back(128'h8ea2b7ca516745bfeafc49904b496089);
        drive_command(mode_encrypt, pt);
        release_inputs();
        close_test("known answer");

        // one block at a time, latency at least 16 cycles
        key_a = {random_block(), random_block()};
        load_key(key_a);
        release_inputs();
        for (int i = 0; i < 20; i++)
        begin
            send_block(key_a, random_block());
            sent_time = $time;
            release_inputs();
            wait_for_results(i + 1);
            if (result_times.size() > i && result_times[i] - sent_time < 16 * CLK_PERIOD)
                report_error($sformatf("block %0d came back after only %0d ns", i,
                    result_times[i] - sent_time));
        end
        close_test("random single blocks");

        // two key entries plus the burst fill the queue
        key_a = {random_block(), random_block()};
        load_key(key_a);
        for (int i = 0; i < `AES_FIFO_DEPTH - 2; i++)
            send_block(key_a, random_block());
        release_inputs();
        close_test("burst ordering");

        // blocks queued before key b still use key a
        key_a = {random_block(), random_block()};
        key_b = {random_block(), random_block()};
        load_key(key_a);
        send_block(key_a, random_block());
        send_block(key_a, random_block());
        load_key(key_b);
        for (int i = 0; i < 3; i++)
            send_block(key_b, random_block());
        release_inputs();
        close_test("re-key in stream");

        // a block still inside the cipher is lost at reset
        drive_command(mode_encrypt, random_block());
        release_inputs();
        repeat (4)
            @(negedge clk);
        apply_reset();
        // key_ready cleared by reset, the block waits at the head
        key_a = {random_block(), random_block()};
        drive_command(mode_encrypt, random_block());
        release_inputs();
        repeat (200)
            @(negedge clk);
        if (results.size() != 0)
            report_error("a result came out after reset with no key loaded");
        // waiting block holds the queue until reset clears it
        apply_reset();
        load_key(key_a);
        send_block(key_a, random_block());
        release_inputs();
        close_test("reset and key readiness");

        $display("%0d tests run, %0d failed, %0d errors", NUM_TESTS, tests_failed, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

// ==== aes256_device.f ====
+incdir+source
+incdir+tests
source/aes_pkg.sv
source/aes_command_fifo.sv
source/aes_dispatch.sv
source/aes_key_expand.sv
source/aes_round_key_store.sv
source/aes_cipher_rounds.sv
source/aes256_device.sv
tests/aes256_device_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the aes256_device testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f aes256_device.f --top-module aes256_device_tb

result=$(./obj_dir/Vaes256_device_tb)
printf '%s\n' "$result"
printf '%s\n' "$result" | grep -q "All tests passed"
